//--- design/alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational ALU
// 33-bit result, bit 32 is carry or borrow
// Overflow, negative, zero, signed-less
// and parity flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module alu (
	input  lapido_isa_pkg::gpr_t       op1,
	input  lapido_isa_pkg::gpr_t       op2,
	input  lapido_isa_pkg::alu_funct_e alu_funct,
	output logic [32:0]                alu_res,
	output logic [4:0]                 flags
);

	logic [32:0]          sum;
	logic [32:0]          diff;
	logic                 ovf;
	lapido_isa_pkg::gpr_t res;

	assign sum  = {1'b0, op1} + {1'b0, op2};
	assign diff = {1'b0, op1} - {1'b0, op2}; // Bit 32 set on borrow

	always_comb begin
		ovf     = 1'b0;
		alu_res = '0;
		case (alu_funct)
			lapido_isa_pkg::alu_add: begin
				alu_res = sum;
				ovf     = (op1[31] == op2[31]) && (sum[31] != op1[31]);
			end
			lapido_isa_pkg::alu_sub: begin
				alu_res = diff;
				ovf     = (op1[31] != op2[31]) && (diff[31] != op1[31]);
			end
			lapido_isa_pkg::alu_and:    alu_res = {1'b0, op1 & op2};
			lapido_isa_pkg::alu_or:     alu_res = {1'b0, op1 | op2};
			lapido_isa_pkg::alu_xor:    alu_res = {1'b0, op1 ^ op2};
			lapido_isa_pkg::alu_nor:    alu_res = {1'b0, ~(op1 | op2)};
			lapido_isa_pkg::alu_sll:    alu_res = {1'b0, op1 << op2[4:0]};
			lapido_isa_pkg::alu_srl:    alu_res = {1'b0, op1 >> op2[4:0]};
			lapido_isa_pkg::alu_sra:    alu_res = {1'b0, $signed(op1) >>> op2[4:0]};
			lapido_isa_pkg::alu_slt:    alu_res = {32'b0, $signed(op1) < $signed(op2)};
			lapido_isa_pkg::alu_pass_b: alu_res = {1'b0, op2};
			default:                    alu_res = '0; // Unknown code, carry clear
		endcase
	end

	assign res = alu_res[31:0];

	// Flags come from the 32-bit result only
	assign flags[lapido_isa_pkg::flag_ovf]  = ovf;
	assign flags[lapido_isa_pkg::flag_neg]  = res[31];
	assign flags[lapido_isa_pkg::flag_zero] = (res == '0);
	assign flags[lapido_isa_pkg::flag_slt]  = res[31] ^ ovf; // Signed less than
	assign flags[lapido_isa_pkg::flag_par]  = ^res;

endmodule

//--- design/ex_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage
// Forwarding operand muxes and ALU
// Destination select and flag register
// Branch target adder
// EX/MEM register with branch flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ex_stage (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        branch_taken,    // Squash the instruction in EX
	input  lapido_isa_pkg::gpr_addr_t   rs,
	input  lapido_isa_pkg::gpr_addr_t   rt,
	input  lapido_isa_pkg::gpr_addr_t   rd,
	input  lapido_isa_pkg::gpr_t        data_rs,
	input  lapido_isa_pkg::gpr_t        data_rt,
	input  lapido_isa_pkg::gpr_t        imm,
	input  lapido_isa_pkg::pc_t         next_pc,
	input  lapido_isa_pkg::alu_funct_e  alu_funct,
	input  lapido_ctrl_pkg::alu_src_e   alu_src,
	input  lapido_ctrl_pkg::reg_dst_e   reg_dst,
	input  logic                        fl_write_enable,
	input  logic                        mem_write_enable,
	input  logic                        sel_beq_bne,
	input  logic                        sel_jt_jf,
	input  logic                        is_branch,
	input  logic                        sel_jflag_branch,
	input  lapido_ctrl_pkg::wb_src_e    wb_src,
	input  logic                        reg_write_enable,
	input  lapido_ctrl_pkg::fwd_sel_e   fwd_a,
	input  lapido_ctrl_pkg::fwd_sel_e   fwd_b,
	input  lapido_isa_pkg::gpr_t        ex_mem_fwd_data, // EX/MEM ALU result
	input  lapido_isa_pkg::gpr_t        mem_wb_data,     // MEM/WB write-back value
	output lapido_isa_pkg::gpr_t        ex_mem_alu_res,
	output lapido_isa_pkg::gpr_t        ex_mem_data,     // Store data
	output lapido_isa_pkg::gpr_t        ex_mem_imm,
	output lapido_isa_pkg::pc_t         ex_mem_next_pc,
	output lapido_isa_pkg::pc_t         ex_mem_branch_addr,
	output lapido_isa_pkg::gpr_addr_t   ex_mem_dest,
	output lapido_isa_pkg::gpr_addr_t   ex_mem_flag_code, // Flag index for jt and jf
	output lapido_isa_pkg::flags_t      flags,
	output logic                        ex_mem_write_enable,
	output logic                        ex_mem_mem_write_enable,
	output logic                        ex_mem_sel_beq_bne,
	output logic                        ex_mem_sel_jt_jf,
	output logic                        ex_mem_is_branch,
	output logic                        ex_mem_sel_jflag_branch,
	output lapido_ctrl_pkg::wb_src_e    ex_mem_wb_src
);

	lapido_isa_pkg::gpr_t      op_a;
	lapido_isa_pkg::gpr_t      op_b;
	lapido_isa_pkg::gpr_t      st_data;
	lapido_isa_pkg::gpr_addr_t dest;
	logic [32:0]               alu_res;
	logic [4:0]                alu_flags;

	function automatic lapido_isa_pkg::gpr_t fwd_mux(lapido_ctrl_pkg::fwd_sel_e sel,
			lapido_isa_pkg::gpr_t reg_val);
		case (sel)
			lapido_ctrl_pkg::fwd_from_ex:  return ex_mem_fwd_data;
			lapido_ctrl_pkg::fwd_from_mem: return mem_wb_data;
			default:                       return reg_val;
		endcase
	endfunction

	assign op_a    = fwd_mux(fwd_a, data_rs);
	assign st_data = fwd_mux(fwd_b, data_rt); // Stores always see the forwarded rt
	assign op_b    = (alu_src == lapido_ctrl_pkg::alu_src_imm) ? imm : st_data;

	alu u_alu (
		.op1       (op_a),
		.op2       (op_b),
		.alu_funct (alu_funct),
		.alu_res   (alu_res),
		.flags     (alu_flags)
	);

	always_comb begin
		case (reg_dst)
			lapido_ctrl_pkg::reg_dst_rd:  dest = rd;
			lapido_ctrl_pkg::reg_dst_rt:  dest = rt;
			lapido_ctrl_pkg::reg_dst_r15: dest = lapido_isa_pkg::reg_15;
			default:                      dest = '0;
		endcase
	end

	// Control and branch fields, a taken branch loads a bubble
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ex_mem_dest             <= '0;
			ex_mem_flag_code        <= '0;
			ex_mem_branch_addr      <= '0;
			ex_mem_write_enable     <= 1'b0;
			ex_mem_mem_write_enable <= 1'b0;
			ex_mem_sel_beq_bne      <= 1'b0;
			ex_mem_sel_jt_jf        <= 1'b0;
			ex_mem_is_branch        <= 1'b0;
			ex_mem_sel_jflag_branch <= 1'b0;
			ex_mem_wb_src           <= lapido_ctrl_pkg::wb_alu;
		end else begin
			ex_mem_dest             <= branch_taken ? '0 : dest;
			ex_mem_flag_code        <= branch_taken ? '0 : rs;
			ex_mem_branch_addr      <= branch_taken ? '0 : next_pc + imm[15:0];
			ex_mem_write_enable     <= reg_write_enable & ~branch_taken;
			ex_mem_mem_write_enable <= mem_write_enable & ~branch_taken;
			ex_mem_sel_beq_bne      <= sel_beq_bne & ~branch_taken;
			ex_mem_sel_jt_jf        <= sel_jt_jf & ~branch_taken;
			ex_mem_is_branch        <= is_branch & ~branch_taken;
			ex_mem_sel_jflag_branch <= sel_jflag_branch & ~branch_taken;
			ex_mem_wb_src           <= wb_src;
		end
	end

	// Data fields
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ex_mem_alu_res <= '0;
			ex_mem_data    <= '0;
			ex_mem_imm     <= '0;
			ex_mem_next_pc <= '0;
		end else begin
			ex_mem_alu_res <= alu_res[31:0];
			ex_mem_data    <= st_data;
			ex_mem_imm     <= imm;
			ex_mem_next_pc <= next_pc; // Return address for links
		end
	end

	// Flag register, a squashed instruction leaves it alone
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			flags <= '0;
		end else if (fl_write_enable && !branch_taken) begin
			flags[lapido_isa_pkg::flag_carry] <= alu_res[32];
			flags[4:0]                        <= alu_flags;
		end
	end

	a_fwd_codes: assert property (@(posedge clk) disable iff (rst)
		fwd_a inside {lapido_ctrl_pkg::fwd_none, lapido_ctrl_pkg::fwd_from_ex,
			lapido_ctrl_pkg::fwd_from_mem} &&
		fwd_b inside {lapido_ctrl_pkg::fwd_none, lapido_ctrl_pkg::fwd_from_ex,
			lapido_ctrl_pkg::fwd_from_mem})
		else $error("Unused forward select code");

	a_reg_dst_code: assert property (@(posedge clk) disable iff (rst)
		reg_dst inside {lapido_ctrl_pkg::reg_dst_rd, lapido_ctrl_pkg::reg_dst_rt,
			lapido_ctrl_pkg::reg_dst_r15})
		else $error("Unused reg_dst code");

endmodule

//--- design/forwarding_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Forwarding unit
// RAW detection against EX/MEM and MEM/WB
// EX/MEM match has priority
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module forwarding_unit (
	input  lapido_isa_pkg::gpr_addr_t  rs,
	input  lapido_isa_pkg::gpr_addr_t  rt,
	input  lapido_isa_pkg::gpr_addr_t  ex_mem_dest,
	input  lapido_isa_pkg::gpr_addr_t  mem_wb_dest,
	input  logic                       ex_mem_write_enable,
	input  logic                       mem_wb_write_enable,
	output lapido_ctrl_pkg::fwd_sel_e  fwd_a,
	output lapido_ctrl_pkg::fwd_sel_e  fwd_b
);

	// Select for one source register
	function automatic lapido_ctrl_pkg::fwd_sel_e fwd_sel(lapido_isa_pkg::gpr_addr_t src);
		if (ex_mem_write_enable && ex_mem_dest != '0 && ex_mem_dest == src)
			return lapido_ctrl_pkg::fwd_from_ex; // Youngest result wins
		else if (mem_wb_write_enable && mem_wb_dest != '0 && mem_wb_dest == src)
			return lapido_ctrl_pkg::fwd_from_mem; // Register 0 never matches
		else
			return lapido_ctrl_pkg::fwd_none;
	endfunction

	assign fwd_a = fwd_sel(rs);
	assign fwd_b = fwd_sel(rt);

endmodule

//--- design/lapido_ctrl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline mux select encodings
// Forwarding, ALU operand B, destination
// and write-back source selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lapido_ctrl_pkg;

	typedef enum logic [1:0] {
		fwd_none     = 2'd0, // Register file value
		fwd_from_ex  = 2'd1, // EX/MEM ALU result
		fwd_from_mem = 2'd2  // MEM/WB write-back value
	} fwd_sel_e;

	typedef enum logic {
		alu_src_reg = 1'b0,
		alu_src_imm = 1'b1
	} alu_src_e;

	typedef enum logic [1:0] {
		reg_dst_rd  = 2'd0,
		reg_dst_rt  = 2'd1,
		reg_dst_r15 = 2'd2 // Link register for calls
	} reg_dst_e;

	typedef enum logic [1:0] {
		wb_alu     = 2'd0,
		wb_mem     = 2'd1, // Load data
		wb_imm     = 2'd2,
		wb_next_pc = 2'd3  // Return address
	} wb_src_e;

endpackage

//--- design/lapido_ex_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute slice top level
// Forwarding unit, EX stage and MEM stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module lapido_ex_top (
	input  logic                       clk,
	input  logic                       rst,
	input  lapido_isa_pkg::gpr_addr_t  rs,
	input  lapido_isa_pkg::gpr_addr_t  rt,
	input  lapido_isa_pkg::gpr_addr_t  rd,
	input  lapido_isa_pkg::gpr_t       data_rs,
	input  lapido_isa_pkg::gpr_t       data_rt,
	input  lapido_isa_pkg::gpr_t       imm,
	input  lapido_isa_pkg::pc_t        next_pc,
	input  lapido_isa_pkg::alu_funct_e alu_funct,
	input  lapido_ctrl_pkg::alu_src_e  alu_src,
	input  lapido_ctrl_pkg::reg_dst_e  reg_dst,
	input  logic                       fl_write_enable,
	input  logic                       id_mem_write_enable, // ID/EX store enable
	input  logic                       sel_beq_bne,
	input  logic                       sel_jt_jf,
	input  logic                       is_branch,
	input  logic                       sel_jflag_branch,
	input  lapido_ctrl_pkg::wb_src_e   wb_src,
	input  logic                       reg_write_enable,
	input  lapido_isa_pkg::gpr_t       load_data,
	output logic                       branch_taken,
	output lapido_isa_pkg::pc_t        branch_target,
	output logic                       mem_write_enable,    // Data memory port
	output lapido_isa_pkg::gpr_t       mem_addr,
	output lapido_isa_pkg::gpr_t       mem_data,
	output lapido_isa_pkg::gpr_t       wb_data,
	output lapido_isa_pkg::gpr_addr_t  wb_dest,
	output logic                       wb_write_enable,
	output lapido_isa_pkg::flags_t     flags
);

	lapido_ctrl_pkg::fwd_sel_e fwd_a;
	lapido_ctrl_pkg::fwd_sel_e fwd_b;
	lapido_isa_pkg::gpr_t      ex_mem_alu_res;
	lapido_isa_pkg::gpr_t      ex_mem_data;
	lapido_isa_pkg::gpr_t      ex_mem_imm;
	lapido_isa_pkg::pc_t       ex_mem_next_pc;
	lapido_isa_pkg::pc_t       ex_mem_branch_addr;
	lapido_isa_pkg::gpr_addr_t ex_mem_dest;
	lapido_isa_pkg::gpr_addr_t ex_mem_flag_code;
	logic                      ex_mem_write_enable;
	logic                      ex_mem_mem_write_enable;
	logic                      ex_mem_sel_beq_bne;
	logic                      ex_mem_sel_jt_jf;
	logic                      ex_mem_is_branch;
	logic                      ex_mem_sel_jflag_branch;
	lapido_ctrl_pkg::wb_src_e  ex_mem_wb_src;

	forwarding_unit u_forwarding_unit (
		.rs(rs), .rt(rt),
		.ex_mem_dest(ex_mem_dest), .mem_wb_dest(wb_dest), // MEM/WB is the write-back register
		.ex_mem_write_enable(ex_mem_write_enable), .mem_wb_write_enable(wb_write_enable),
		.fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	ex_stage u_ex_stage (
		.clk(clk), .rst(rst), .branch_taken(branch_taken),
		.rs(rs), .rt(rt), .rd(rd), .data_rs(data_rs), .data_rt(data_rt),
		.imm(imm), .next_pc(next_pc), .alu_funct(alu_funct), .alu_src(alu_src),
		.reg_dst(reg_dst), .fl_write_enable(fl_write_enable),
		.mem_write_enable(id_mem_write_enable), .sel_beq_bne(sel_beq_bne),
		.sel_jt_jf(sel_jt_jf), .is_branch(is_branch), .sel_jflag_branch(sel_jflag_branch),
		.wb_src(wb_src), .reg_write_enable(reg_write_enable),
		.fwd_a(fwd_a), .fwd_b(fwd_b),
		.ex_mem_fwd_data(ex_mem_alu_res), .mem_wb_data(wb_data),
		.ex_mem_alu_res(ex_mem_alu_res), .ex_mem_data(ex_mem_data), .ex_mem_imm(ex_mem_imm),
		.ex_mem_next_pc(ex_mem_next_pc), .ex_mem_branch_addr(ex_mem_branch_addr),
		.ex_mem_dest(ex_mem_dest), .ex_mem_flag_code(ex_mem_flag_code), .flags(flags),
		.ex_mem_write_enable(ex_mem_write_enable),
		.ex_mem_mem_write_enable(ex_mem_mem_write_enable),
		.ex_mem_sel_beq_bne(ex_mem_sel_beq_bne), .ex_mem_sel_jt_jf(ex_mem_sel_jt_jf),
		.ex_mem_is_branch(ex_mem_is_branch), .ex_mem_sel_jflag_branch(ex_mem_sel_jflag_branch),
		.ex_mem_wb_src(ex_mem_wb_src)
	);

	mem_stage u_mem_stage (
		.clk(clk), .rst(rst),
		.ex_mem_alu_res(ex_mem_alu_res), .ex_mem_data(ex_mem_data), .ex_mem_imm(ex_mem_imm),
		.ex_mem_next_pc(ex_mem_next_pc), .ex_mem_branch_addr(ex_mem_branch_addr),
		.ex_mem_dest(ex_mem_dest), .ex_mem_flag_code(ex_mem_flag_code),
		.ex_mem_write_enable(ex_mem_write_enable),
		.ex_mem_mem_write_enable(ex_mem_mem_write_enable),
		.ex_mem_sel_beq_bne(ex_mem_sel_beq_bne), .ex_mem_sel_jt_jf(ex_mem_sel_jt_jf),
		.ex_mem_is_branch(ex_mem_is_branch), .ex_mem_sel_jflag_branch(ex_mem_sel_jflag_branch),
		.ex_mem_wb_src(ex_mem_wb_src), .flags(flags), .load_data(load_data),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.mem_write_enable(mem_write_enable), .mem_addr(mem_addr), .mem_data(mem_data),
		.wb_data(wb_data), .wb_dest(wb_dest), .wb_write_enable(wb_write_enable)
	);

endmodule

//--- design/lapido_isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction-set definitions of the core
// Data, register index and PC widths
// ALU function codes
// Flag register bit positions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lapido_isa_pkg;

	localparam int unsigned gpr_width      = 32; // Data word
	localparam int unsigned gpr_addr_width = 4;  // 16 registers
	localparam int unsigned pc_width       = 16; // Word addressed
	localparam int unsigned flag_width     = 6;

	typedef logic [gpr_width-1:0]      gpr_t;
	typedef logic [gpr_addr_width-1:0] gpr_addr_t;
	typedef logic [pc_width-1:0]       pc_t;
	typedef logic [flag_width-1:0]     flags_t;

	// Flag register layout, bits 4..0 also match the ALU flag output
	localparam int unsigned flag_carry = 5;
	localparam int unsigned flag_ovf   = 4;
	localparam int unsigned flag_neg   = 3;
	localparam int unsigned flag_zero  = 2;
	localparam int unsigned flag_slt   = 1; // Negative xor overflow
	localparam int unsigned flag_par   = 0; // Even parity

	typedef enum logic [5:0] {
		alu_add    = 6'd0,
		alu_sub    = 6'd1,
		alu_and    = 6'd2,
		alu_or     = 6'd3,
		alu_xor    = 6'd4,
		alu_nor    = 6'd5,
		alu_sll    = 6'd6,
		alu_srl    = 6'd7,
		alu_sra    = 6'd8,
		alu_slt    = 6'd9,
		alu_pass_b = 6'd10
	} alu_funct_e;

	localparam gpr_addr_t reg_15 = 4'd15; // Link register

endpackage

//--- design/mem_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory stage
// Branch resolution for beq, bne, jt, jf
// Data memory port drive
// Write-back select and MEM/WB register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mem_stage (
	input  logic                       clk,
	input  logic                       rst,
	input  lapido_isa_pkg::gpr_t       ex_mem_alu_res,
	input  lapido_isa_pkg::gpr_t       ex_mem_data,
	input  lapido_isa_pkg::gpr_t       ex_mem_imm,
	input  lapido_isa_pkg::pc_t        ex_mem_next_pc,
	input  lapido_isa_pkg::pc_t        ex_mem_branch_addr,
	input  lapido_isa_pkg::gpr_addr_t  ex_mem_dest,
	input  lapido_isa_pkg::gpr_addr_t  ex_mem_flag_code,
	input  logic                       ex_mem_write_enable,
	input  logic                       ex_mem_mem_write_enable,
	input  logic                       ex_mem_sel_beq_bne,
	input  logic                       ex_mem_sel_jt_jf,
	input  logic                       ex_mem_is_branch,
	input  logic                       ex_mem_sel_jflag_branch,
	input  lapido_ctrl_pkg::wb_src_e   ex_mem_wb_src,
	input  lapido_isa_pkg::flags_t     flags,
	input  lapido_isa_pkg::gpr_t       load_data,
	output logic                       branch_taken,
	output lapido_isa_pkg::pc_t        branch_target,
	output logic                       mem_write_enable,
	output lapido_isa_pkg::gpr_t       mem_addr,
	output lapido_isa_pkg::gpr_t       mem_data,
	output lapido_isa_pkg::gpr_t       wb_data,
	output lapido_isa_pkg::gpr_addr_t  wb_dest,
	output logic                       wb_write_enable
);

	logic [2:0]           flag_idx;
	logic                 zero_cond;
	logic                 flag_cond;
	lapido_isa_pkg::gpr_t wb_next;

	assign flag_idx  = ex_mem_flag_code[2:0];
	assign zero_cond = (ex_mem_alu_res == '0) ^ ex_mem_sel_beq_bne; // beq 0, bne 1
	// jt wants the flag set and jf wants it clear
	assign flag_cond = (flag_idx < 3'(lapido_isa_pkg::flag_width)) && // No flag at 6 or 7
		(flags[flag_idx] ^ ex_mem_sel_jt_jf);

	assign branch_taken  = ex_mem_is_branch && (ex_mem_sel_jflag_branch ? flag_cond : zero_cond);
	assign branch_target = ex_mem_branch_addr;

	assign mem_write_enable = ex_mem_mem_write_enable;
	assign mem_addr         = ex_mem_alu_res;
	assign mem_data         = ex_mem_data;

	always_comb begin
		case (ex_mem_wb_src)
			lapido_ctrl_pkg::wb_mem:     wb_next = load_data;
			lapido_ctrl_pkg::wb_imm:     wb_next = ex_mem_imm;
			lapido_ctrl_pkg::wb_next_pc: wb_next = {16'b0, ex_mem_next_pc};
			default:                     wb_next = ex_mem_alu_res;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wb_data         <= '0;
			wb_dest         <= '0;
			wb_write_enable <= 1'b0;
		end else begin
			wb_data         <= wb_next;
			wb_dest         <= ex_mem_dest;
			wb_write_enable <= ex_mem_write_enable;
		end
	end

endmodule

//--- lapido_ex.f
design/lapido_isa_pkg.sv
design/lapido_ctrl_pkg.sv
design/alu.sv
design/forwarding_unit.sv
design/ex_stage.sv
design/mem_stage.sv
design/lapido_ex_top.sv
tests/clock_gen.sv
tests/tb_lapido_ex.sv

//--- tests/clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
// 4 ns clock, reset held for 2 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // Half period 2 ns
	end

	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1 rst = 1'b0; // Released just after the second edge
	end

endmodule

//--- tests/tb_lapido_ex.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the execute slice
// Random instruction stimulus
// Cycle model of EX/MEM, MEM/WB and flags
// Typed compare tasks and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_lapido_ex;

	localparam int num_instr   = 3000;
	localparam int watchdog_ns = 2 * num_instr * 4 + 100;

	logic                       clk;
	logic                       rst;
	lapido_isa_pkg::gpr_addr_t  rs;
	lapido_isa_pkg::gpr_addr_t  rt;
	lapido_isa_pkg::gpr_addr_t  rd;
	lapido_isa_pkg::gpr_t       data_rs;
	lapido_isa_pkg::gpr_t       data_rt;
	lapido_isa_pkg::gpr_t       imm;
	lapido_isa_pkg::pc_t        next_pc;
	lapido_isa_pkg::alu_funct_e alu_funct;
	lapido_ctrl_pkg::alu_src_e  alu_src;
	lapido_ctrl_pkg::reg_dst_e  reg_dst;
	logic                       fl_write_enable;
	logic                       id_mem_write_enable;
	logic                       sel_beq_bne;
	logic                       sel_jt_jf;
	logic                       is_branch;
	logic                       sel_jflag_branch;
	lapido_ctrl_pkg::wb_src_e   wb_src;
	logic                       reg_write_enable;
	lapido_isa_pkg::gpr_t       load_data;
	logic                       branch_taken;
	lapido_isa_pkg::pc_t        branch_target;
	logic                       mem_write_enable;
	lapido_isa_pkg::gpr_t       mem_addr;
	lapido_isa_pkg::gpr_t       mem_data;
	lapido_isa_pkg::gpr_t       wb_data;
	lapido_isa_pkg::gpr_addr_t  wb_dest;
	logic                       wb_write_enable;
	lapido_isa_pkg::flags_t     flags;

	// Model of the EX/MEM register
	lapido_isa_pkg::gpr_t       m_alu_res   = '0;
	lapido_isa_pkg::gpr_t       m_data      = '0;
	lapido_isa_pkg::gpr_t       m_imm       = '0;
	lapido_isa_pkg::pc_t        m_next_pc   = '0;
	lapido_isa_pkg::pc_t        m_br_addr   = '0;
	lapido_isa_pkg::gpr_addr_t  m_dest      = '0;
	lapido_isa_pkg::gpr_addr_t  m_flag_code = '0;
	logic                       m_we        = 1'b0;
	logic                       m_mwe       = 1'b0;
	logic                       m_beq_bne   = 1'b0;
	logic                       m_jt_jf     = 1'b0;
	logic                       m_is_branch = 1'b0;
	logic                       m_jflag     = 1'b0;
	lapido_ctrl_pkg::wb_src_e   m_wb_src    = lapido_ctrl_pkg::wb_alu;
	// Model of the flag register and MEM/WB
	lapido_isa_pkg::flags_t     m_flags     = '0;
	lapido_isa_pkg::gpr_t       m_wb_data   = '0;
	lapido_isa_pkg::gpr_addr_t  m_wb_dest   = '0;
	logic                       m_wb_we     = 1'b0;

	int n_taken  = 0;
	int n_stores = 0;

	clock_gen u_clock_gen (.clk(clk), .rst(rst));

	lapido_ex_top u_lapido_ex_top (
		.clk(clk), .rst(rst), .rs(rs), .rt(rt), .rd(rd),
		.data_rs(data_rs), .data_rt(data_rt), .imm(imm), .next_pc(next_pc),
		.alu_funct(alu_funct), .alu_src(alu_src), .reg_dst(reg_dst),
		.fl_write_enable(fl_write_enable), .id_mem_write_enable(id_mem_write_enable),
		.sel_beq_bne(sel_beq_bne), .sel_jt_jf(sel_jt_jf), .is_branch(is_branch),
		.sel_jflag_branch(sel_jflag_branch), .wb_src(wb_src),
		.reg_write_enable(reg_write_enable), .load_data(load_data),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.mem_write_enable(mem_write_enable), .mem_addr(mem_addr), .mem_data(mem_data),
		.wb_data(wb_data), .wb_dest(wb_dest), .wb_write_enable(wb_write_enable),
		.flags(flags)
	);

	task automatic stop_on_failure();
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first mismatch");
	endtask

	task automatic check_gpr(input lapido_isa_pkg::gpr_t got, input lapido_isa_pkg::gpr_t exp,
			input string what);
		if (got !== exp) begin
			$display("[ERROR] t=%0t: %s is %h, expected %h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_addr(input lapido_isa_pkg::gpr_addr_t got,
			input lapido_isa_pkg::gpr_addr_t exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] t=%0t: %s is %0d, expected %0d", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_pc(input lapido_isa_pkg::pc_t got, input lapido_isa_pkg::pc_t exp,
			input string what);
		if (got !== exp) begin
			$display("[ERROR] t=%0t: %s is %h, expected %h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_flags(input lapido_isa_pkg::flags_t got,
			input lapido_isa_pkg::flags_t exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] t=%0t: %s is %b, expected %b", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] t=%0t: %s is %b, expected %b", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	// Reference ALU, overflow found by exact 64-bit arithmetic
	task automatic alu_ref(input lapido_isa_pkg::gpr_t a, input lapido_isa_pkg::gpr_t b,
			input lapido_isa_pkg::alu_funct_e f, output logic carry,
			output lapido_isa_pkg::gpr_t r, output logic ovf);
		longint sa;
		longint sb;
		longint exact;
		sa    = longint'($signed(a));
		sb    = longint'($signed(b));
		exact = 0;
		carry = 1'b0;
		ovf   = 1'b0;
		r     = '0;
		case (f)
			lapido_isa_pkg::alu_add: begin
				r     = a + b;
				exact = sa + sb;
				carry = (longint'(a) + longint'(b)) > longint'(32'hffff_ffff);
				ovf   = exact != longint'($signed(r)); // Sum does not fit 32 bits
			end
			lapido_isa_pkg::alu_sub: begin
				r     = a - b;
				exact = sa - sb;
				carry = a < b; // Borrow
				ovf   = exact != longint'($signed(r));
			end
			lapido_isa_pkg::alu_and:    r = a & b;
			lapido_isa_pkg::alu_or:     r = a | b;
			lapido_isa_pkg::alu_xor:    r = a ^ b;
			lapido_isa_pkg::alu_nor:    r = ~(a | b);
			lapido_isa_pkg::alu_sll:    r = a << b[4:0];
			lapido_isa_pkg::alu_srl:    r = a >> b[4:0];
			lapido_isa_pkg::alu_sra:    r = $unsigned($signed(a) >>> b[4:0]);
			lapido_isa_pkg::alu_slt:    r = (sa < sb) ? 32'd1 : 32'd0;
			lapido_isa_pkg::alu_pass_b: r = b;
			default:                    r = '0; // Unknown code
		endcase
	endtask

	// Branch decision of the instruction held in the model EX/MEM
	function automatic logic model_taken();
		int idx;
		idx = int'(m_flag_code[2:0]);
		if (!m_is_branch)
			return 1'b0;
		if (m_jflag) begin
			if (idx > 5)
				return 1'b0; // No flag at 6 or 7
			if (!m_jt_jf)
				return m_flags[idx]; // jt
			return !m_flags[idx];    // jf
		end
		if (!m_beq_bne)
			return m_alu_res == '0;  // beq
		return m_alu_res != '0;      // bne
	endfunction

	function automatic lapido_isa_pkg::gpr_t forward_value(lapido_isa_pkg::gpr_addr_t src,
			lapido_isa_pkg::gpr_t reg_val);
		if (src == '0)
			return reg_val; // Register 0 always reads the file
		if (m_we && m_dest == src)
			return m_alu_res;
		if (m_wb_we && m_wb_dest == src)
			return m_wb_data;
		return reg_val;
	endfunction

	// One rising edge of the model, inputs are those driven before the edge
	task automatic model_step();
		logic                      taken;
		logic                      carry;
		logic                      ovf;
		lapido_isa_pkg::gpr_t      op_a;
		lapido_isa_pkg::gpr_t      op_b;
		lapido_isa_pkg::gpr_t      store_val;
		lapido_isa_pkg::gpr_t      res;
		lapido_isa_pkg::gpr_t      wb_val;
		lapido_isa_pkg::gpr_addr_t dest;
		taken     = model_taken();
		op_a      = forward_value(rs, data_rs);
		store_val = forward_value(rt, data_rt);
		op_b      = (alu_src == lapido_ctrl_pkg::alu_src_imm) ? imm : store_val;
		alu_ref(op_a, op_b, alu_funct, carry, res, ovf);
		case (reg_dst)
			lapido_ctrl_pkg::reg_dst_rt:  dest = rt;
			lapido_ctrl_pkg::reg_dst_r15: dest = 4'd15;
			default:                      dest = rd;
		endcase
		case (m_wb_src)
			lapido_ctrl_pkg::wb_mem:     wb_val = load_data;
			lapido_ctrl_pkg::wb_imm:     wb_val = m_imm;
			lapido_ctrl_pkg::wb_next_pc: wb_val = {16'h0000, m_next_pc};
			default:                     wb_val = m_alu_res;
		endcase
		m_wb_data = wb_val; // MEM/WB from the old EX/MEM
		m_wb_dest = m_dest;
		m_wb_we   = m_we;
		if (fl_write_enable && !taken) begin
			m_flags[lapido_isa_pkg::flag_carry] = carry;
			m_flags[lapido_isa_pkg::flag_ovf]   = ovf;
			m_flags[lapido_isa_pkg::flag_neg]   = res[31];
			m_flags[lapido_isa_pkg::flag_zero]  = res == '0;
			m_flags[lapido_isa_pkg::flag_slt]   = res[31] != ovf;
			m_flags[lapido_isa_pkg::flag_par]   = ($countones(res) % 2) == 1;
		end
		m_alu_res = res;
		m_data    = store_val;
		m_imm     = imm;
		m_next_pc = next_pc;
		m_wb_src  = wb_src;
		if (taken) begin // Bubble behind a taken branch
			m_dest      = '0;
			m_flag_code = '0;
			m_br_addr   = '0;
			m_we        = 1'b0;
			m_mwe       = 1'b0;
			m_beq_bne   = 1'b0;
			m_jt_jf     = 1'b0;
			m_is_branch = 1'b0;
			m_jflag     = 1'b0;
		end else begin
			m_dest      = dest;
			m_flag_code = rs;
			m_br_addr   = next_pc + imm[15:0];
			m_we        = reg_write_enable;
			m_mwe       = id_mem_write_enable;
			m_beq_bne   = sel_beq_bne;
			m_jt_jf     = sel_jt_jf;
			m_is_branch = is_branch;
			m_jflag     = sel_jflag_branch;
		end
	endtask

	task automatic drive_nop();
		rs                  = '0;
		rt                  = '0;
		rd                  = '0;
		data_rs             = '0;
		data_rt             = '0;
		imm                 = '0;
		next_pc             = '0;
		alu_funct           = lapido_isa_pkg::alu_add;
		alu_src             = lapido_ctrl_pkg::alu_src_reg;
		reg_dst             = lapido_ctrl_pkg::reg_dst_rd;
		fl_write_enable     = 1'b0;
		id_mem_write_enable = 1'b0;
		sel_beq_bne         = 1'b0;
		sel_jt_jf           = 1'b0;
		is_branch           = 1'b0;
		sel_jflag_branch    = 1'b0;
		wb_src              = lapido_ctrl_pkg::wb_alu;
		reg_write_enable    = 1'b0;
		load_data           = '0;
	endtask

	function automatic lapido_isa_pkg::alu_funct_e pick_funct();
		if ($urandom_range(15, 0) == 0)
			return lapido_isa_pkg::alu_funct_e'(6'($urandom_range(63, 11))); // Unused code
		return lapido_isa_pkg::alu_funct_e'(6'($urandom_range(10, 0)));
	endfunction

	task automatic drive_random_instr();
		int kind;
		kind                = $urandom_range(99, 0);
		rs                  = 4'($urandom_range(5, 0)); // Few registers, many hazards
		rt                  = 4'($urandom_range(5, 0));
		rd                  = 4'($urandom_range(5, 0));
		data_rs             = $urandom();
		data_rt             = $urandom();
		imm                 = $urandom();
		next_pc             = 16'($urandom());
		load_data           = $urandom();
		alu_funct           = pick_funct();
		alu_src             = lapido_ctrl_pkg::alu_src_e'($urandom_range(1, 0));
		reg_dst             = lapido_ctrl_pkg::reg_dst_e'($urandom_range(2, 0));
		fl_write_enable     = 1'($urandom_range(1, 0));
		id_mem_write_enable = 1'b0;
		sel_beq_bne         = 1'($urandom_range(1, 0));
		sel_jt_jf           = 1'($urandom_range(1, 0));
		is_branch           = 1'b0;
		sel_jflag_branch    = 1'b0;
		wb_src              = lapido_ctrl_pkg::wb_src_e'($urandom_range(3, 0));
		reg_write_enable    = $urandom_range(9, 0) != 0;
		if (kind < 10) begin // Branch
			is_branch        = 1'b1;
			reg_write_enable = 1'b0;
			sel_jflag_branch = 1'($urandom_range(1, 0));
			if (sel_jflag_branch) begin
				rs = 4'($urandom_range(7, 0)); // Flag index, 6 and 7 included
			end else begin
				alu_funct = lapido_isa_pkg::alu_sub;
				alu_src   = lapido_ctrl_pkg::alu_src_reg;
				if ($urandom_range(1, 0) == 1)
					data_rt = data_rs; // Equal operands unless forwarded
			end
		end else if (kind < 25) begin // Store
			id_mem_write_enable = 1'b1;
			reg_write_enable    = 1'b0;
			alu_funct           = lapido_isa_pkg::alu_add;
			alu_src             = lapido_ctrl_pkg::alu_src_imm;
		end else if (kind < 40) begin // Load
			wb_src           = lapido_ctrl_pkg::wb_mem;
			reg_write_enable = 1'b1;
			alu_funct        = lapido_isa_pkg::alu_add;
			alu_src          = lapido_ctrl_pkg::alu_src_imm;
		end
	endtask

	// Outputs sampled late in the cycle
	task automatic compare_outputs();
		logic exp_taken;
		exp_taken = model_taken();
		check_bit(branch_taken, exp_taken, "branch_taken");
		check_pc(branch_target, m_br_addr, "branch_target");
		check_bit(mem_write_enable, m_mwe, "mem_write_enable");
		check_gpr(mem_addr, m_alu_res, "mem_addr");
		if (m_mwe)
			check_gpr(mem_data, m_data, "mem_data");
		check_bit(wb_write_enable, m_wb_we, "wb_write_enable");
		check_addr(wb_dest, m_wb_dest, "wb_dest");
		if (m_wb_we)
			check_gpr(wb_data, m_wb_data, "wb_data");
		check_flags(flags, m_flags, "flags");
		if (exp_taken)
			n_taken++;
		if (m_mwe)
			n_stores++;
	endtask

	initial begin
		#(watchdog_ns);
		$display("Timeout: the run did not finish within %0d ns", watchdog_ns);
		stop_on_failure();
	end

	initial begin
		void'($urandom(32'h2698));
		drive_nop();
		@(negedge rst);
		#1;
		check_bit(wb_write_enable, 1'b0, "wb_write_enable after reset");
		check_bit(mem_write_enable, 1'b0, "mem_write_enable after reset");
		check_bit(branch_taken, 1'b0, "branch_taken after reset");
		check_flags(flags, '0, "flags after reset");
		for (int i = 0; i < num_instr + 3; i++) begin
			@(posedge clk);
			model_step();
			#1;
			if (i < num_instr)
				drive_random_instr();
			else
				drive_nop(); // Drain the pipeline
			#2;
			compare_outputs();
		end
		$display("Instructions: %0d, branches taken: %0d, stores: %0d",
			num_instr, n_taken, n_stores);
		$display("Test completed successfully");
		$finish;
	end

endmodule
